// File: Bender.yml
package:
  name: fpu_top

sources:
  - design/fp_format_pkg.sv
  - design/fpu_op_pkg.sv
  - design/fp_operand_stage.sv
  - design/fp_addsub.sv
  - design/fp_mul.sv
  - design/fpu_result_select.sv
  - design/fpu_top.sv
  - target: test
    files:
      - tb/fpu_top_assertions.sv
      - tb/fpu_top_tb.sv

// File: design/fp_addsub.sv
`default_nettype none
`timescale 1ns/1ns

module fp_addsub (
  input  fpu_op_pkg::fpu_op_e      stage_op,
  input  fpu_op_pkg::fpu_operand_t opa,
  input  fpu_op_pkg::fpu_operand_t opb,
  output fp_format_pkg::fp_word_t  addsub_result
);

  logic         b_sign_eff;    // b sign with the subtract folded in
  logic         a_smaller;     // a has the smaller exponent
  logic   [7:0] exp_diff;
  logic   [4:0] align_shift;   // clamped, 31 already clears the field
  logic  [23:0] small_man;
  logic  [55:0] small_wide;    // upper 28 field bits, lower 28 spilled bits
  logic [25:-3] small_aligned;
  logic [25:-3] a_aligned;     // 2 upper guards, 24 mantissa, g r s
  logic [25:-3] b_aligned;
  logic [25:-3] a_signed;
  logic [25:-3] b_signed;
  logic [25:-3] sum;
  logic [25:-3] sum_abs;
  logic [25:-3] sum_fixed;     // carry shifted out
  logic   [8:0] exp_big;
  logic   [8:0] exp_carry;
  logic   [5:0] lz;
  logic   [5:0] norm_shift;
  logic [25:-3] man_norm;
  logic   [8:0] exp_norm;
  logic [25:-3] man_sub;
  logic         round_up;
  logic  [25:0] man_rounded;
  logic  [25:0] man_renorm;
  logic   [8:0] exp_renorm;
  logic   [7:0] exp_field;
  logic         res_sign;

  assign b_sign_eff = opb.unp.sign ^ (stage_op == fpu_op_pkg::op_sub); // a - b is a + (-b)

  // alignment of the smaller operand
  assign a_smaller   = opa.unp.exp < opb.unp.exp;
  assign exp_diff    = a_smaller ? opb.unp.exp - opa.unp.exp : opa.unp.exp - opb.unp.exp;
  assign align_shift = (exp_diff > 8'd31) ? 5'd31 : exp_diff[4:0];
  assign small_man   = a_smaller ? opa.unp.man : opb.unp.man;
  assign small_wide  = {2'b00, small_man, 2'b00, 28'h0} >> align_shift;
  assign small_aligned = {small_wide[55:28], |small_wide[27:0]}; // spilled bits become sticky

  assign a_aligned = a_smaller ? small_aligned : {2'b00, opa.unp.man, 3'b000};
  assign b_aligned = a_smaller ? {2'b00, opb.unp.man, 3'b000} : small_aligned;
  assign a_signed  = opa.unp.sign ? -a_aligned : a_aligned;
  assign b_signed  = b_sign_eff ? -b_aligned : b_aligned;

  assign sum      = a_signed + b_signed;
  assign res_sign = sum[25];
  assign sum_abs  = sum[25] ? -sum : sum;

  // carry out of bit 23 moves the point one place left
  assign exp_big   = {1'b0, a_smaller ? opb.unp.exp : opa.unp.exp};
  assign exp_carry = exp_big + 9'(sum_abs[24]);
  assign sum_fixed = sum_abs[24] ? {1'b0, sum_abs[25:-1], sum_abs[-2] | sum_abs[-3]} : sum_abs;

  // 3 pad bits plus the two guard positions
  assign lz = fp_format_pkg::lzc32({3'b000, sum_fixed}) - 6'd5;

  // never shift the exponent below zero
  assign norm_shift = (exp_carry < 9'(lz)) ? exp_carry[5:0] : lz;
  assign man_norm   = sum_fixed << norm_shift;
  assign exp_norm   = exp_carry - 9'(norm_shift);

  // exponent 0 means 0.xxx * 2^-126, so one more place right
  assign man_sub = (exp_norm == 9'd0) ? {1'b0, man_norm[25:-1], man_norm[-2] | man_norm[-3]}
                                      : man_norm;

  // nearest even, ties look at the lsb
  assign round_up    = man_sub[-1] && (man_sub[-2] || man_sub[-3] || man_sub[0]);
  assign man_rounded = man_sub[25:0] + 26'(round_up);
  assign man_renorm  = man_rounded[24] ? (man_rounded >> 1) : man_rounded;
  assign exp_renorm  = exp_norm + 9'(man_rounded[24]);
  // a subnormal that rounds up to the hidden bit becomes the smallest normal
  assign exp_field   = (exp_renorm == 9'd0 && man_renorm[23]) ? 8'd1 : exp_renorm[7:0];

  always_comb begin
    if (opa.cls.is_nan) begin
      addsub_result = opa.raw;                   // nan passes through
    end else if (opb.cls.is_nan) begin
      addsub_result = opb.raw;
    end else if (opa.cls.is_inf && opb.cls.is_inf && (opa.unp.sign != b_sign_eff)) begin
      addsub_result = fp_format_pkg::qnan_word;  // inf - inf
    end else if (opa.cls.is_inf) begin
      addsub_result = {opa.unp.sign, fp_format_pkg::exp_max, 23'h0};
    end else if (opb.cls.is_inf) begin
      addsub_result = {b_sign_eff, fp_format_pkg::exp_max, 23'h0};
    end else if (man_renorm == '0) begin
      addsub_result = '0;                        // exact cancel gives +0
    end else if (exp_renorm >= {1'b0, fp_format_pkg::exp_max}) begin
      addsub_result = {res_sign, fp_format_pkg::exp_max, 23'h0}; // overflow
    end else begin
      addsub_result = {res_sign, exp_field, man_renorm[22:0]};
    end
  end

endmodule

`default_nettype wire

// File: design/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

  localparam int exp_w    = 8;
  localparam int frac_w   = 23;
  localparam int man_w    = 24;   // fraction plus hidden bit
  localparam int exp_bias = 127;

  localparam logic [exp_w-1:0] exp_max = 8'hff;

  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [frac_w-1:0] frac;
  } fp_word_t;

  localparam fp_word_t qnan_word = 32'h7fc00000; // default quiet nan
  localparam fp_word_t one_word  = 32'h3f800000; // +1.0

  typedef struct packed {
    logic is_nan;
    logic is_inf;
    logic is_zero;
    logic is_subnormal;
    logic is_one;       // exactly +1.0
  } fp_class_t;

  // effective exponent is 01 for subnormals, mantissa carries the hidden bit
  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exp;
    logic [man_w-1:0] man;
  } fp_unpacked_t;

  // the highest set bit is the last one seen going up
  function automatic logic [5:0] lzc32(input logic [31:0] a);
    logic [5:0] cnt;
    cnt = 6'd32;
    for (int i = 0; i < 32; i++) begin
      if (a[i]) cnt = 6'(31 - i);
    end
    return cnt;
  endfunction

  function automatic logic [5:0] lzc48(input logic [47:0] a);
    logic [5:0] cnt;
    cnt = 6'd48;
    for (int i = 0; i < 48; i++) begin
      if (a[i]) cnt = 6'(47 - i);
    end
    return cnt;
  endfunction

endpackage

`default_nettype wire

// File: design/fp_mul.sv
`default_nettype none
`timescale 1ns/1ns

module fp_mul (
  input  fpu_op_pkg::fpu_operand_t opa,
  input  fpu_op_pkg::fpu_operand_t opb,
  output fp_format_pkg::fp_word_t  mul_result
);

  logic              res_sign;
  logic       [47:0] product;     // msb weighs 2^1
  logic signed [9:0] exp_sum;     // unbiased, may drop below -127
  logic signed [9:0] exp_shift1;
  logic       [47:0] prod_norm;
  logic        [5:0] lz;
  logic signed [9:0] exp_left;
  logic       [47:0] man_left;
  logic              underflow;
  logic signed [9:0] sub_shift;
  logic        [5:0] sub_shamt;
  logic       [95:0] man_wide;    // lower half catches shifted-out bits
  logic       [47:0] man_norm;
  logic signed [9:0] exp_norm;
  logic              round_up;
  logic       [24:0] man_rounded;
  logic       [24:0] man_renorm;
  logic signed [9:0] exp_renorm;
  logic signed [9:0] exp_biased;
  logic        [7:0] exp_field;

  assign res_sign = opa.unp.sign ^ opb.unp.sign;
  assign product  = opa.unp.man * opb.unp.man;

  assign exp_sum = $signed({2'b00, opa.unp.exp}) + $signed({2'b00, opb.unp.exp})
                 - $signed(10'(2 * fp_format_pkg::exp_bias));

  // first normalization puts 2^0 at bit 47
  assign exp_shift1 = exp_sum + $signed({9'b0, product[47]});
  assign prod_norm  = product[47] ? product : (product << 1);

  // leading zeros come from subnormal inputs
  assign lz       = fp_format_pkg::lzc48(prod_norm);
  assign exp_left = exp_shift1 - $signed({4'b0, lz});
  assign man_left = prod_norm << lz;

  // below -126 shift right into the subnormal range, exponent clamps to -127
  assign underflow = exp_left < -10'sd126;
  assign sub_shift = -10'sd126 - exp_left;
  assign sub_shamt = (sub_shift > 10'sd63) ? 6'd63 : sub_shift[5:0];
  assign man_wide  = {man_left, 48'h0} >> sub_shamt;
  assign man_norm  = underflow ? {man_wide[95:49], man_wide[48] | (|man_wide[47:0])} : man_left;
  assign exp_norm  = underflow ? -10'sd127 : exp_left;

  // keep bits 47:24, bit 23 is guard
  assign round_up    = man_norm[23] && ((|man_norm[22:0]) || man_norm[24]);
  assign man_rounded = {1'b0, man_norm[47:24]} + 25'(round_up);
  assign man_renorm  = man_rounded[24] ? (man_rounded >> 1) : man_rounded;
  assign exp_renorm  = exp_norm + $signed({9'b0, man_rounded[24]});
  assign exp_biased  = exp_renorm + $signed(10'(fp_format_pkg::exp_bias));
  assign exp_field   = (exp_biased == 10'sd0 && man_renorm[23]) ? 8'd1 : exp_biased[7:0];

  always_comb begin
    if (opa.cls.is_nan || opb.cls.is_nan) begin
      mul_result = fp_format_pkg::qnan_word;
    end else if ((opa.cls.is_zero && opb.cls.is_inf) || (opa.cls.is_inf && opb.cls.is_zero)) begin
      mul_result = fp_format_pkg::qnan_word;   // 0 * inf
    end else if (opa.cls.is_inf || opb.cls.is_inf) begin
      mul_result = {res_sign, fp_format_pkg::exp_max, 23'h0};
    end else if (opa.cls.is_zero || opb.cls.is_zero) begin
      mul_result = {res_sign, 8'h00, 23'h0};   // signed zero
    end else if (opa.cls.is_one) begin
      mul_result = {res_sign, opb.raw.exp, opb.raw.frac};
    end else if (opb.cls.is_one) begin
      mul_result = {res_sign, opa.raw.exp, opa.raw.frac};
    end else if (exp_sum > $signed(10'(fp_format_pkg::exp_bias)) ||
                 exp_biased >= $signed({2'b00, fp_format_pkg::exp_max})) begin
      mul_result = {res_sign, fp_format_pkg::exp_max, 23'h0}; // overflow to inf
    end else begin
      mul_result = {res_sign, exp_field, man_renorm[22:0]};
    end
  end

endmodule

`default_nettype wire

// File: design/fp_operand_stage.sv
`default_nettype none
`timescale 1ns/1ns

module fp_operand_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  fpu_op_pkg::fpu_req_t     req,
  output logic                     stage_valid,
  output fpu_op_pkg::fpu_op_e      stage_op,
  output fpu_op_pkg::fpu_operand_t opa,
  output fpu_op_pkg::fpu_operand_t opb
);

  fp_format_pkg::fp_word_t a_q; // registered raw operands
  fp_format_pkg::fp_word_t b_q;

  // classify one word and expand it to sign, effective exponent, 24-bit mantissa
  function automatic fpu_op_pkg::fpu_operand_t unpack_operand(input fp_format_pkg::fp_word_t w);
    fpu_op_pkg::fpu_operand_t o;
    logic exp_zero;
    logic exp_ones;
    logic frac_zero;
    exp_zero  = (w.exp == '0);
    exp_ones  = (w.exp == fp_format_pkg::exp_max);
    frac_zero = (w.frac == '0);
    o.raw              = w;
    o.cls.is_nan       = exp_ones && !frac_zero;
    o.cls.is_inf       = exp_ones && frac_zero;
    o.cls.is_zero      = exp_zero && frac_zero;
    o.cls.is_subnormal = exp_zero && !frac_zero;
    o.cls.is_one       = (w == fp_format_pkg::one_word);
    o.unp.sign = w.sign;
    o.unp.exp  = o.cls.is_subnormal ? 8'h01 : w.exp; // subnormals live at 2^-126
    o.unp.man  = {!exp_zero, w.frac};                 // no hidden bit for zero or subnormal
    return o;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
      stage_op    <= fpu_op_pkg::op_add;
    end else begin
      stage_valid <= in_valid;
      if (in_valid) stage_op <= req.op;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_q <= req.a;
      b_q <= req.b;
    end
  end

  assign opa = unpack_operand(a_q);
  assign opb = unpack_operand(b_q);

endmodule

`default_nettype wire

// File: design/fpu_op_pkg.sv
`default_nettype none

package fpu_op_pkg;

  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } fpu_op_e;

  // one operation as it enters the unit
  typedef struct packed {
    fpu_op_e                 op;
    fp_format_pkg::fp_word_t a;
    fp_format_pkg::fp_word_t b;
  } fpu_req_t;

  // operand after classification and unpacking
  typedef struct packed {
    fp_format_pkg::fp_word_t     raw;
    fp_format_pkg::fp_class_t    cls;
    fp_format_pkg::fp_unpacked_t unp;
  } fpu_operand_t;

endpackage

`default_nettype wire

// File: design/fpu_result_select.sv
`default_nettype none
`timescale 1ns/1ns

module fpu_result_select (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stage_valid,
  input  fpu_op_pkg::fpu_op_e     stage_op,
  input  fp_format_pkg::fp_word_t addsub_result,
  input  fp_format_pkg::fp_word_t mul_result,
  output logic                    out_valid,
  output fp_format_pkg::fp_word_t result
);

  fp_format_pkg::fp_word_t selected;

  always_comb begin
    case (stage_op)
      fpu_op_pkg::op_mul: selected = mul_result;
      default:            selected = addsub_result; // add and sub share a datapath
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= stage_valid;        // one pulse per operation
      if (stage_valid) result <= selected; // holds between results
    end
  end

endmodule

`default_nettype wire

// File: design/fpu_top.sv
`default_nettype none
`timescale 1ns/1ns

module fpu_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  fpu_op_pkg::fpu_req_t    req,
  output logic                    out_valid,
  output fp_format_pkg::fp_word_t result
);

  logic                     stage_valid;
  fpu_op_pkg::fpu_op_e      stage_op;
  fpu_op_pkg::fpu_operand_t opa;         // unpacked operands, cycle 1
  fpu_op_pkg::fpu_operand_t opb;
  fp_format_pkg::fp_word_t  addsub_result;
  fp_format_pkg::fp_word_t  mul_result;

  fp_operand_stage u_operand_stage (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .req         (req),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .opa         (opa),
    .opb         (opb)
  );

  fp_addsub u_addsub (
    .stage_op      (stage_op),
    .opa           (opa),
    .opb           (opb),
    .addsub_result (addsub_result)
  );

  fp_mul u_mul (
    .opa        (opa),
    .opb        (opb),
    .mul_result (mul_result)
  );

  fpu_result_select u_result_select (
    .clk           (clk),
    .reset         (reset),
    .stage_valid   (stage_valid),
    .stage_op      (stage_op),
    .addsub_result (addsub_result),
    .mul_result    (mul_result),
    .out_valid     (out_valid),
    .result        (result)
  );

endmodule

`default_nettype wire

// File: fpu_top.f
design/fp_format_pkg.sv
design/fpu_op_pkg.sv
design/fp_operand_stage.sv
design/fp_addsub.sv
design/fp_mul.sv
design/fpu_result_select.sv
design/fpu_top.sv
tb/fpu_top_assertions.sv
tb/fpu_top_tb.sv

// File: tb/fpu_top_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_top_assertions (
  input logic                    clk,
  input logic                    reset,
  input logic                    in_valid,
  input fpu_op_pkg::fpu_req_t    req,
  input logic                    out_valid,
  input fp_format_pkg::fp_word_t result
);

  // second reset edge onward, the output register is already cleared
  reset_clears_valid: assert property (@(posedge clk) reset && $past(reset) |-> !out_valid)
    else $error("out_valid high while reset is held");

  valid_after_two: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> ##2 out_valid)
    else $error("accepted operation produced no out_valid two cycles later");

  no_extra_valid: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> $past(in_valid, 2))
    else $error("out_valid without an operation two cycles earlier");

  // a multiply never hands back a signaling nan
  mul_nan_quiet: assert property (@(posedge clk) disable iff (reset)
    (out_valid && $past(in_valid, 2) && $past(req.op, 2) == fpu_op_pkg::op_mul &&
     result.exp == fp_format_pkg::exp_max && result.frac != '0) |-> result.frac[22])
    else $error("multiply result is a nan with the quiet bit clear");

endmodule

bind fpu_top fpu_top_assertions u_fpu_top_assertions (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .req       (req),
  .out_valid (out_valid),
  .result    (result)
);

`default_nettype wire

// File: tb/fpu_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_top_tb;

  localparam int num_vec        = 31;
  localparam int timeout_cycles = num_vec * 2 + 20;  // every op plus a possible idle slot
  localparam logic [31:0] lfsr_seed = 32'h383b7ef2;
  localparam logic [31:0] lfsr_taps = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

  typedef struct packed {
    fpu_op_pkg::fpu_op_e     op;
    fp_format_pkg::fp_word_t a;
    fp_format_pkg::fp_word_t b;
    fp_format_pkg::fp_word_t want;  // round to nearest even
  } vector_t;

  logic                    clk;
  logic                    reset;
  logic                    in_valid;
  fpu_op_pkg::fpu_req_t    req;
  logic                    out_valid;
  fp_format_pkg::fp_word_t result;

  vector_t                 vectors [num_vec];
  fp_format_pkg::fp_word_t expect_q [$];  // results still in flight
  fp_format_pkg::fp_word_t want_word;
  logic [1:0]              issue_hist;    // in_valid at the last two rising edges
  logic [31:0]             lfsr_state;
  int                      checked;

  fpu_top u_fpu_top (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .result    (result)
  );

  always begin
    clk = 1'b0;
    #4;
    clk = 1'b1;
    #4;
  end

  function automatic vector_t make_vector(input fpu_op_pkg::fpu_op_e op,
                                          input fp_format_pkg::fp_word_t a,
                                          input fp_format_pkg::fp_word_t b,
                                          input fp_format_pkg::fp_word_t want);
    vector_t v;
    v.op   = op;
    v.a    = a;
    v.b    = b;
    v.want = want;
    return v;
  endfunction

  // galois form, shifts right and folds the taps in on a one
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  task automatic load_vectors();
    vectors[0]  = make_vector(fpu_op_pkg::op_add, 32'h3f800000, 32'h3f800000, 32'h40000000);
    vectors[1]  = make_vector(fpu_op_pkg::op_add, 32'h3f800000, 32'h40000000, 32'h40400000);
    vectors[2]  = make_vector(fpu_op_pkg::op_add, 32'h3fc00000, 32'h40200000, 32'h40800000);
    vectors[3]  = make_vector(fpu_op_pkg::op_sub, 32'h3f800000, 32'h3f800000, 32'h00000000);
    vectors[4]  = make_vector(fpu_op_pkg::op_sub, 32'h40400000, 32'h3f800000, 32'h40000000);
    vectors[5]  = make_vector(fpu_op_pkg::op_sub, 32'h3f800000, 32'h40400000, 32'hc0000000);
    // tie at 2^-24, stays on the even 1.0
    vectors[6]  = make_vector(fpu_op_pkg::op_add, 32'h3f800000, 32'h33800000, 32'h3f800000);
    vectors[7]  = make_vector(fpu_op_pkg::op_add, 32'h3f800000, 32'h33800001, 32'h3f800001); // sticky
    vectors[8]  = make_vector(fpu_op_pkg::op_add, 32'h3f800001, 32'h33800000, 32'h3f800002); // odd tie
    vectors[9]  = make_vector(fpu_op_pkg::op_add, 32'h00000001, 32'h00000001, 32'h00000002);
    vectors[10] = make_vector(fpu_op_pkg::op_add, 32'h00400000, 32'h00400000, 32'h00800000);
    vectors[11] = make_vector(fpu_op_pkg::op_sub, 32'h00800001, 32'h00800000, 32'h00000001);
    vectors[12] = make_vector(fpu_op_pkg::op_sub, 32'h01000000, 32'h00c00000, 32'h00400000);
    vectors[13] = make_vector(fpu_op_pkg::op_add, 32'h7fa00001, 32'h3f800000, 32'h7fa00001); // snan
    vectors[14] = make_vector(fpu_op_pkg::op_sub, 32'h3f800000, 32'hffc12345, 32'hffc12345);
    vectors[15] = make_vector(fpu_op_pkg::op_add, 32'h7f800000, 32'hff800000, 32'h7fc00000);
    vectors[16] = make_vector(fpu_op_pkg::op_sub, 32'h7f800000, 32'h7f800000, 32'h7fc00000);
    vectors[17] = make_vector(fpu_op_pkg::op_add, 32'hff800000, 32'h3f800000, 32'hff800000);
    vectors[18] = make_vector(fpu_op_pkg::op_mul, 32'h40000000, 32'h40400000, 32'h40c00000);
    vectors[19] = make_vector(fpu_op_pkg::op_mul, 32'h3fc00000, 32'h3fc00000, 32'h40100000);
    vectors[20] = make_vector(fpu_op_pkg::op_mul, 32'hc0000000, 32'h40400000, 32'hc0c00000);
    // 2 - 2^-45 rounds up past the top and renormalizes
    vectors[21] = make_vector(fpu_op_pkg::op_mul, 32'h3ffffffe, 32'h3f800001, 32'h40000000);
    vectors[22] = make_vector(fpu_op_pkg::op_mul, 32'h0dc00000, 32'h30800000, 32'h000c0000);
    vectors[23] = make_vector(fpu_op_pkg::op_mul, 32'h3f800000, 32'hc0490fdb, 32'hc0490fdb);
    vectors[24] = make_vector(fpu_op_pkg::op_mul, 32'h40490fdb, 32'h3f800000, 32'h40490fdb);
    vectors[25] = make_vector(fpu_op_pkg::op_mul, 32'h7f000000, 32'h40000000, 32'h7f800000);
    vectors[26] = make_vector(fpu_op_pkg::op_mul, 32'hff000000, 32'h40000000, 32'hff800000);
    vectors[27] = make_vector(fpu_op_pkg::op_mul, 32'h00000000, 32'h7f800000, 32'h7fc00000);
    vectors[28] = make_vector(fpu_op_pkg::op_mul, 32'h7fa00000, 32'h3f800000, 32'h7fc00000);
    vectors[29] = make_vector(fpu_op_pkg::op_mul, 32'h80000000, 32'h40000000, 32'h80000000);
    vectors[30] = make_vector(fpu_op_pkg::op_mul, 32'h80000000, 32'hc0000000, 32'h00000000);
  endtask

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_word(input fp_format_pkg::fp_word_t got,
                            input fp_format_pkg::fp_word_t want, input int idx);
    if (got !== want) begin
      $display("[FAIL] %0t ns result got %h expected %h (vector %0d)", $time, got, want, idx);
      stop_run();
    end
  endtask

  task automatic check_valid(input logic got, input logic want);
    if (got !== want) begin
      $display("[FAIL] %0t ns out_valid got %b expected %b", $time, got, want);
      stop_run();
    end
  endtask

  // two register stages, so the pulse matches in_valid from two edges back
  always @(posedge clk) begin
    if (reset) issue_hist <= 2'b00;
    else       issue_hist <= {issue_hist[0], in_valid};
  end

  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);  // outputs settled since the rising edge
      check_valid(out_valid, issue_hist[1]);
      if (out_valid) begin
        if (expect_q.size() == 0) begin
          $display("out_valid pulsed at %0t ns with no operation in flight", $time);
          stop_run();
        end else begin
          want_word = expect_q.pop_front();
          check_word(result, want_word, checked);
          checked++;
        end
      end
    end
  end

  initial begin
    reset      = 1'b1;
    in_valid   = 1'b0;
    req        = '0;
    lfsr_state = lfsr_seed;
    checked    = 0;
    load_vectors();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      if (lfsr_state[0]) begin  // one bit decides on an idle cycle
        in_valid = 1'b0;
        @(negedge clk);
      end
      in_valid = 1'b1;
      req.op   = vectors[i].op;
      req.a    = vectors[i].a;
      req.b    = vectors[i].b;
      expect_q.push_back(vectors[i].want);
      @(negedge clk);
    end
    in_valid = 1'b0;
    while (expect_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);  // catches a stray late pulse
    @(posedge clk);             // last falling-edge check has run
    if (checked == num_vec) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("only %0d of %0d results were checked", checked, num_vec);
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout, the results never arrived within %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
